/* design/rename_params.svh */
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Superscalar width
`define N 2

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

`define ARCH_IDX_BITS 5
`define PHYS_IDX_BITS 6

// Holds any count from 0 to N
`define COUNT_BITS 2

`endif

/* design/rename_pkg.sv */
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    typedef logic [`ARCH_IDX_BITS-1:0] arch_reg_idx;
    typedef logic [`PHYS_IDX_BITS-1:0] phys_reg_idx;

    // Instruction classes seen by rename
    typedef enum logic [3:0] {
        alu_reg,
        alu_imm,
        load,
        store,
        branch,
        lui,
        jal,
        system,
        bad
    } inst_kind;

    typedef struct packed {
        logic [31:0] pc;
        inst_kind    kind;
        arch_reg_idx rd;
        arch_reg_idx rs1;
        arch_reg_idx rs2;
        logic        rs1_used;
        logic        rs2_used;
        logic        has_dest;  // Writes a non-zero rd
        logic        illegal;
        logic        halt;      // ecall or ebreak
        logic [31:0] imm;
    } decode_packet;

    typedef struct packed {
        decode_packet inst;
        phys_reg_idx  t_new;
        phys_reg_idx  source1;
        logic         source1_ready;
        phys_reg_idx  source2;
        logic         source2_ready;
    } rs_packet;

    typedef struct packed {
        phys_reg_idx t_new;
        phys_reg_idx t_old;     // Freed when this entry retires
        arch_reg_idx arch_reg;
        logic        halt;
        logic        illegal;
        logic [31:0] npc;
    } rob_packet;

endpackage

`default_nettype wire

/* design/inst_decoder.sv */
`default_nettype none
`timescale 1ns/1ns

`include "rename_params.svh"

module inst_decoder (
    input  logic [`N-1:0][31:0]              raw_insts,
    input  logic [`N-1:0][31:0]              pcs,
    output rename_pkg::decode_packet [`N-1:0] decode_packets
);

    import rename_pkg::*;

    function automatic decode_packet decode_one(
        input logic [31:0] inst,
        input logic [31:0] pc
    );
        decode_packet pkt;
        logic         writes;
        pkt = '0;
        writes = 1'b0;
        pkt.pc = pc;
        pkt.rd = inst[11:7];
        pkt.rs1 = inst[19:15];
        pkt.rs2 = inst[24:20];
        case (inst[6:0])
            7'b0110011: begin
                pkt.kind = alu_reg;
                pkt.rs1_used = 1'b1;
                pkt.rs2_used = 1'b1;
                writes = 1'b1;
            end
            7'b0010011: begin
                pkt.kind = alu_imm;
                pkt.rs1_used = 1'b1;
                pkt.imm = {{20{inst[31]}}, inst[31:20]};
                writes = 1'b1;
            end
            7'b0000011: begin
                pkt.kind = load;
                pkt.rs1_used = 1'b1;
                pkt.imm = {{20{inst[31]}}, inst[31:20]};
                writes = 1'b1;
            end
            7'b0100011: begin
                pkt.kind = store;                // Base and data, no dest
                pkt.rs1_used = 1'b1;
                pkt.rs2_used = 1'b1;
                pkt.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            7'b1100011: begin
                pkt.kind = branch;
                pkt.rs1_used = 1'b1;
                pkt.rs2_used = 1'b1;
                pkt.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            7'b0110111, 7'b0010111: begin
                pkt.kind = lui;                  // auipc shares the U format
                pkt.imm = {inst[31:12], 12'b0};
                writes = 1'b1;
            end
            7'b1101111: begin
                pkt.kind = jal;
                pkt.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                writes = 1'b1;
            end
            7'b1100111: begin
                pkt.kind = jal;                  // jalr reads its base
                pkt.rs1_used = 1'b1;
                pkt.imm = {{20{inst[31]}}, inst[31:20]};
                writes = 1'b1;
            end
            7'b1110011: begin
                pkt.kind = system;
                pkt.halt = (inst == 32'h0000_0073) || (inst == 32'h0010_0073);
            end
            default: begin
                pkt.kind = bad;
                pkt.illegal = 1'b1;
            end
        endcase
        // x0 is never renamed
        pkt.has_dest = writes && (pkt.rd != '0);
        return pkt;
    endfunction

    always_comb begin
        for (int i = 0; i < `N; i++) begin
            decode_packets[i] = decode_one(raw_insts[i], pcs[i]);
        end
    end

endmodule

`default_nettype wire

/* design/rename_dispatch.sv */
`default_nettype none
`timescale 1ns/1ns

`include "rename_params.svh"

module rename_dispatch (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [`COUNT_BITS-1:0]            insts_valid,
    input  rename_pkg::decode_packet [`N-1:0] decode_packets,
    input  rename_pkg::phys_reg_idx [`N-1:0]  regs_to_use,
    input  logic [`COUNT_BITS-1:0]            free_count,
    input  logic [`PHYS_REGS-1:0]             ready_bits,
    input  rename_pkg::phys_reg_idx [`N-1:0]  complete_tags,
    input  logic [`N-1:0]                     complete_valid,
    input  logic [`COUNT_BITS-1:0]            rs_spots,
    input  logic [`COUNT_BITS-1:0]            rob_spots,
    output rename_pkg::rs_packet [`N-1:0]     rs_entries,
    output rename_pkg::rob_packet [`N-1:0]    rob_entries,
    output logic [`COUNT_BITS-1:0]            num_dispatched
);

    import rename_pkg::*;

    phys_reg_idx [`ARCH_REGS-1:0] map_table;
    phys_reg_idx [`ARCH_REGS-1:0] next_map_table;

    // Arch regs renamed earlier in this group
    logic [`ARCH_REGS-1:0] fresh;

    logic [`COUNT_BITS-1:0] min_supply;
    logic [`COUNT_BITS-1:0] min_spots;
    logic [`COUNT_BITS-1:0] dispatch_limit;

    // Ready from the complete list or bypassed from this cycle's completions
    function automatic logic tag_ready(
        input phys_reg_idx                 tag,
        input logic [`PHYS_REGS-1:0]       ready,
        input phys_reg_idx [`N-1:0]        tags,
        input logic [`N-1:0]               tags_valid
    );
        logic hit;
        hit = ready[tag];
        for (int j = 0; j < `N; j++) begin
            if (tags_valid[j] && (tags[j] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign min_supply = (insts_valid < free_count) ? insts_valid : free_count;
    assign min_spots = (rs_spots < rob_spots) ? rs_spots : rob_spots;
    assign dispatch_limit = (min_supply < min_spots) ? min_supply : min_spots;

    always_comb begin
        next_map_table = map_table;
        fresh = '0;
        rs_entries = '0;
        rob_entries = '0;
        num_dispatched = '0;
        for (int i = 0; i < `N; i++) begin
            if (i < dispatch_limit) begin
                rs_entries[i].inst = decode_packets[i];
                rs_entries[i].t_new = regs_to_use[i];

                // Running map so a later slot sees earlier destinations
                rs_entries[i].source1 = next_map_table[decode_packets[i].rs1];
                rs_entries[i].source2 = next_map_table[decode_packets[i].rs2];

                // A producer in this same group cannot have completed yet
                rs_entries[i].source1_ready = !decode_packets[i].rs1_used
                    || (!fresh[decode_packets[i].rs1]
                        && tag_ready(rs_entries[i].source1, ready_bits,
                                     complete_tags, complete_valid));
                rs_entries[i].source2_ready = !decode_packets[i].rs2_used
                    || (!fresh[decode_packets[i].rs2]
                        && tag_ready(rs_entries[i].source2, ready_bits,
                                     complete_tags, complete_valid));

                rob_entries[i].t_new = regs_to_use[i];
                rob_entries[i].t_old = decode_packets[i].has_dest
                    ? next_map_table[decode_packets[i].rd] : regs_to_use[i];
                rob_entries[i].arch_reg = decode_packets[i].rd;
                rob_entries[i].halt = decode_packets[i].halt;
                rob_entries[i].illegal = decode_packets[i].illegal;
                rob_entries[i].npc = decode_packets[i].pc + 32'd4;

                if (decode_packets[i].has_dest) begin
                    next_map_table[decode_packets[i].rd] = regs_to_use[i];
                    fresh[decode_packets[i].rd] = 1'b1;
                end

                // Every slot takes a tag, with or without a destination
                num_dispatched = `COUNT_BITS'(i + 1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                map_table[a] <= phys_reg_idx'(a);   // Identity mapping
            end
        end else begin
            map_table <= next_map_table;
        end
    end

    // A group holds at most N instructions
    valid_within_group: assert property (
        @(posedge clock) disable iff (reset)
        insts_valid <= `N
    ) else $error("Group of %0d instructions is wider than %0d", insts_valid, `N);

endmodule

`default_nettype wire

/* design/free_list.sv */
`default_nettype none
`timescale 1ns/1ns

`include "rename_params.svh"

module free_list (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [`COUNT_BITS-1:0]           num_dispatched,
    input  rename_pkg::phys_reg_idx          retire_tag,
    input  logic                             retire_valid,
    output rename_pkg::phys_reg_idx [`N-1:0] regs_to_use,
    output logic [`COUNT_BITS-1:0]           free_count
);

    import rename_pkg::*;

    logic [`PHYS_REGS-1:0] free_bits;
    logic [`PHYS_REGS-1:0] next_free;
    logic [`PHYS_REGS-1:0] remaining;
    logic [`N-1:0]         found;

    // Pick the N lowest free tags, one after another
    always_comb begin
        remaining = free_bits;
        free_count = '0;
        for (int k = 0; k < `N; k++) begin
            regs_to_use[k] = '0;
            found[k] = 1'b0;
            for (int p = `PHYS_REGS - 1; p >= 0; p--) begin
                if (remaining[p]) begin
                    regs_to_use[k] = phys_reg_idx'(p);  // Lowest index wins
                    found[k] = 1'b1;
                end
            end
            if (found[k]) begin
                remaining[regs_to_use[k]] = 1'b0;
                free_count = free_count + 1'b1;          // Saturates at N
            end
        end
    end

    always_comb begin
        next_free = free_bits;
        for (int k = 0; k < `N; k++) begin
            if (k < num_dispatched) begin
                next_free[regs_to_use[k]] = 1'b0;
            end
        end
        if (retire_valid) begin
            next_free[retire_tag] = 1'b1;  // Offered again next cycle
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_bits <= {{(`PHYS_REGS - `ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};
        end else begin
            free_bits <= next_free;
        end
    end

    // Retiring a free tag means the ROB and rename disagree
    retire_not_free: assert property (
        @(posedge clock) disable iff (reset)
        retire_valid |-> !free_bits[retire_tag]
    ) else $error("Retired tag %0d was already free", retire_tag);

endmodule

`default_nettype wire

/* design/complete_list.sv */
`default_nettype none
`timescale 1ns/1ns

`include "rename_params.svh"

module complete_list (
    input  logic                             clock,
    input  logic                             reset,
    input  rename_pkg::phys_reg_idx [`N-1:0] complete_tags,
    input  logic [`N-1:0]                    complete_valid,
    input  logic [`COUNT_BITS-1:0]           num_dispatched,
    input  rename_pkg::phys_reg_idx [`N-1:0] regs_to_use,
    output logic [`PHYS_REGS-1:0]            ready_bits
);

    logic [`PHYS_REGS-1:0] next_ready;

    always_comb begin
        next_ready = ready_bits;
        for (int j = 0; j < `N; j++) begin
            if (complete_valid[j]) begin
                next_ready[complete_tags[j]] = 1'b1;
            end
        end
        // Applied last so a fresh allocation always starts not ready
        for (int k = 0; k < `N; k++) begin
            if (k < num_dispatched) begin
                next_ready[regs_to_use[k]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_bits <= {{(`PHYS_REGS - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
        end else begin
            ready_bits <= next_ready;
        end
    end

    // A tag completes once per allocation
    for (genvar j = 0; j < `N; j++) begin : g_complete_check
        complete_not_ready: assert property (
            @(posedge clock) disable iff (reset)
            complete_valid[j] |-> !ready_bits[complete_tags[j]]
        ) else $error("Completion of tag %0d that is already ready", complete_tags[j]);
    end

endmodule

`default_nettype wire

/* design/rename_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "rename_params.svh"

module rename_top (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [`N-1:0][31:0]              raw_insts,
    input  logic [`N-1:0][31:0]              pcs,
    input  logic [`COUNT_BITS-1:0]           insts_valid,
    input  logic [`COUNT_BITS-1:0]           rs_spots,
    input  logic [`COUNT_BITS-1:0]           rob_spots,
    input  rename_pkg::phys_reg_idx [`N-1:0] complete_tags,
    input  logic [`N-1:0]                    complete_valid,
    input  rename_pkg::phys_reg_idx          retire_tag,
    input  logic                             retire_valid,
    output rename_pkg::rs_packet [`N-1:0]    rs_entries,
    output rename_pkg::rob_packet [`N-1:0]   rob_entries,
    output logic [`COUNT_BITS-1:0]           num_dispatched
);

    import rename_pkg::*;

    decode_packet [`N-1:0]  decode_packets;
    phys_reg_idx [`N-1:0]   regs_to_use;   // Offered by the free list
    logic [`COUNT_BITS-1:0] free_count;
    logic [`PHYS_REGS-1:0]  ready_bits;

    inst_decoder decoder0 (
        .raw_insts      (raw_insts),
        .pcs            (pcs),
        .decode_packets (decode_packets)
    );

    rename_dispatch dispatch0 (
        .clock          (clock),
        .reset          (reset),
        .insts_valid    (insts_valid),
        .decode_packets (decode_packets),
        .regs_to_use    (regs_to_use),
        .free_count     (free_count),
        .ready_bits     (ready_bits),
        .complete_tags  (complete_tags),
        .complete_valid (complete_valid),
        .rs_spots       (rs_spots),
        .rob_spots      (rob_spots),
        .rs_entries     (rs_entries),
        .rob_entries    (rob_entries),
        .num_dispatched (num_dispatched)
    );

    free_list free0 (
        .clock          (clock),
        .reset          (reset),
        .num_dispatched (num_dispatched),
        .retire_tag     (retire_tag),
        .retire_valid   (retire_valid),
        .regs_to_use    (regs_to_use),
        .free_count     (free_count)
    );

    // Keeps its own view of the allocated tags
    complete_list complete0 (
        .clock          (clock),
        .reset          (reset),
        .complete_tags  (complete_tags),
        .complete_valid (complete_valid),
        .num_dispatched (num_dispatched),
        .regs_to_use    (regs_to_use),
        .ready_bits     (ready_bits)
    );

endmodule

`default_nettype wire

/* tests/rename_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "rename_params.svh"

module rename_tb;

    import rename_pkg::*;

    localparam int FIELDS = 22;           // Hex words per vector line
    localparam int MAX_VECTORS = 64;
    localparam int RESET_CYCLES = 10;
    localparam logic [31:0] END_MARK = 32'hffff_ffff;

    logic                     clock;
    logic                     reset;
    logic [`N-1:0][31:0]      raw_insts;
    logic [`N-1:0][31:0]      pcs;
    logic [`COUNT_BITS-1:0]   insts_valid;
    logic [`COUNT_BITS-1:0]   rs_spots;
    logic [`COUNT_BITS-1:0]   rob_spots;
    phys_reg_idx [`N-1:0]     complete_tags;
    logic [`N-1:0]            complete_valid;
    phys_reg_idx              retire_tag;
    logic                     retire_valid;
    rs_packet [`N-1:0]        rs_entries;
    rob_packet [`N-1:0]       rob_entries;
    logic [`COUNT_BITS-1:0]   num_dispatched;

    logic [31:0] vectors [0:MAX_VECTORS*FIELDS-1];
    int num_vectors;
    int checks;
    int errors;
    int cycles = 0;
    int cycle_limit = 1000;               // Replaced once the vectors are counted

    rename_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .raw_insts      (raw_insts),
        .pcs            (pcs),
        .insts_valid    (insts_valid),
        .rs_spots       (rs_spots),
        .rob_spots      (rob_spots),
        .complete_tags  (complete_tags),
        .complete_valid (complete_valid),
        .retire_tag     (retire_tag),
        .retire_valid   (retire_valid),
        .rs_entries     (rs_entries),
        .rob_entries    (rob_entries),
        .num_dispatched (num_dispatched)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic drive_idle();
        raw_insts = '0;
        pcs = '0;
        insts_valid = '0;
        rs_spots = '0;
        rob_spots = '0;
        complete_tags = '0;
        complete_valid = '0;
        retire_tag = '0;
        retire_valid = 1'b0;
    endtask

    task automatic load_vectors();
        for (int i = 0; i < MAX_VECTORS * FIELDS; i++) begin
            vectors[i] = END_MARK;
        end
        $readmemh("tests/rename_input.txt", vectors);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && vectors[num_vectors * FIELDS] != END_MARK) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            $display("No vectors could be read from tests/rename_input.txt");
            errors++;
        end
    endtask

    task automatic apply_vector(input int v);
        int base;
        base = v * FIELDS;
        raw_insts[0] = vectors[base];
        raw_insts[1] = vectors[base + 1];
        insts_valid = vectors[base + 3][1:0];
        for (int s = 0; s < `N; s++) begin
            if (s < int'(insts_valid)) begin
                pcs[s] = vectors[base + 2] + 32'(4 * s);
            end else begin
                pcs[s] = $urandom;        // Unused slot, never checked
            end
        end
        rs_spots = vectors[base + 4][1:0];
        rob_spots = vectors[base + 5][1:0];
        complete_valid = vectors[base + 6][1:0];
        complete_tags[0] = vectors[base + 7][5:0];
        complete_tags[1] = vectors[base + 8][5:0];
        retire_valid = vectors[base + 9][0];
        retire_tag = vectors[base + 10][5:0];
    endtask

    task automatic check_slot(input int v, input int s, input int at);
        rs_packet  rs;
        rob_packet rob;
        string     tag;
        rs = rs_entries[s];
        rob = rob_entries[s];
        tag = $sformatf("vector %0d slot %0d", v, s);
        compare_value({tag, " rs t_new"}, vectors[at], 32'(rs.t_new));
        compare_value({tag, " rob t_new"}, vectors[at], 32'(rob.t_new));
        compare_value({tag, " t_old"}, vectors[at + 1], 32'(rob.t_old));
        compare_value({tag, " source1"}, vectors[at + 2], 32'(rs.source1));
        compare_value({tag, " source2"}, vectors[at + 3], 32'(rs.source2));
        compare_value({tag, " halt/illegal/ready flags"}, vectors[at + 4],
                      {28'd0, rob.halt, rob.illegal, rs.source1_ready, rs.source2_ready});
    endtask

    task automatic check_vector(input int v);
        int base;
        int expected_count;
        base = v * FIELDS;
        expected_count = int'(vectors[base + 11]);
        compare_value($sformatf("vector %0d num_dispatched", v), vectors[base + 11],
                      32'(num_dispatched));
        // Entries past the dispatch count carry nothing
        for (int s = 0; s < `N; s++) begin
            if (s < expected_count) begin
                check_slot(v, s, base + 12 + 5 * s);
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        drive_idle();
        checks = 0;
        errors = 0;
        void'($urandom(32'h5bb0a5ea));
        load_vectors();
        cycle_limit = RESET_CYCLES + num_vectors + 30;
        repeat (RESET_CYCLES) @(posedge clock);
        for (int v = 0; v < num_vectors; v++) begin
            #10;
            reset = 1'b0;
            apply_vector(v);
            #70;                          // Outputs settled well before the edge
            check_vector(v);
            @(posedge clock);
        end
        #10;
        drive_idle();
        $display("%0d vectors, %0d checks, %0d errors", num_vectors, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/rename_pkg.sv
design/inst_decoder.sv
design/rename_dispatch.sv
design/free_list.sv
design/complete_list.sv
design/rename_top.sv
tests/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then look for a failure in the log
verilator --binary --timing --assert --top-module rename_tb -f sim.f -o rename_sim \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/rename_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
exit 0

/* tests/rename_input.txt */
// raw0 raw1 pc valid rs_spots rob_spots cvalid ctag0 ctag1 rvalid rtag | num
// per slot: t_new t_old source1 source2 flags{halt,illegal,src1_ready,src2_ready}
003100b3 00000000 1000 1 2 2 0 00 00 0 00 1 20 01 02 03 3 00 00 00 00 0
00208233 001202b3 1008 2 2 2 0 00 00 0 00 2 21 04 20 02 1 22 05 21 20 0
00520333 00130393 1010 2 1 2 0 00 00 0 00 1 23 06 21 22 0 00 00 00 00 0
00130393 00000000 1018 1 2 0 0 00 00 0 00 0 00 00 00 00 0 00 00 00 00 0
00000000 00000000 1020 0 2 2 1 20 00 0 00 0 00 00 00 00 0 00 00 00 00 0
00130393 00408433 1028 2 2 2 1 23 00 0 00 2 24 07 23 20 3 25 08 20 21 2
007304b3 00932023 1030 2 2 2 0 00 00 0 00 2 26 09 23 24 2 27 27 23 26 2
00908063 00508013 1038 2 2 2 0 00 00 0 00 2 28 28 20 26 2 29 29 20 22 3
00000000 00000073 1040 2 2 2 0 00 00 0 00 2 2a 2a 00 00 7 2b 2b 00 00 b
00000533 000005b3 1048 2 2 2 0 00 00 0 00 2 2c 0a 00 00 3 2d 0b 00 00 3
00000533 000005b3 1050 2 2 2 0 00 00 0 00 2 2e 2c 00 00 3 2f 2d 00 00 3
00000533 000005b3 1058 2 2 2 0 00 00 0 00 2 30 2e 00 00 3 31 2f 00 00 3
00000533 000005b3 1060 2 2 2 0 00 00 0 00 2 32 30 00 00 3 33 31 00 00 3
00000533 000005b3 1068 2 2 2 0 00 00 0 00 2 34 32 00 00 3 35 33 00 00 3
00000533 000005b3 1070 2 2 2 0 00 00 0 00 2 36 34 00 00 3 37 35 00 00 3
00000533 000005b3 1078 2 2 2 0 00 00 0 00 2 38 36 00 00 3 39 37 00 00 3
00000533 000005b3 1080 2 2 2 0 00 00 0 00 2 3a 38 00 00 3 3b 39 00 00 3
00000533 000005b3 1088 2 2 2 0 00 00 0 00 2 3c 3a 00 00 3 3d 3b 00 00 3
00000533 000005b3 1090 2 2 2 0 00 00 0 00 2 3e 3c 00 00 3 3f 3d 00 00 3
00000533 000005b3 1098 2 2 2 0 00 00 1 0a 0 00 00 00 00 0 00 00 00 00 0
00b50633 000005b3 10a0 2 2 2 0 00 00 0 00 1 0a 0c 3e 3f 0 00 00 00 00 0
